//--- source/riscv_pkg.sv
package riscv_pkg;

    // ALU operation select driven from the decoder
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // Instruction format as seen by the execute stage
    typedef enum logic [2:0] {
        R_TYPE = 3'd0,
        I_TYPE = 3'd1,
        S_TYPE = 3'd2,
        B_TYPE = 3'd3,
        U_TYPE = 3'd4,
        J_TYPE = 3'd5
    } encoding_t;

    // Operand source for forwarding
    // Code 2'b11 is never produced
    typedef enum logic [1:0] {
        FWD_NONE   = 2'b00,
        FWD_MEM_WB = 2'b01,
        FWD_EX_MEM = 2'b10
    } forward_sel_t;

endpackage

//--- source/alu.sv
`timescale 1ns/1ns

module alu (
    input  riscv_pkg::alu_op_t control,
    input  logic [31:0]        left_operand,
    input  logic [31:0]        right_operand,
    output logic [31:0]        result,
    output logic               zero_flag
);

    logic [4:0] shamt;

    // RV32I only looks at the low five bits for shifts
    assign shamt = right_operand[4:0];

    always_comb begin
        case (control)
            riscv_pkg::ALU_ADD: begin
                result = left_operand + right_operand;
            end
            riscv_pkg::ALU_SUB: begin
                result = left_operand - right_operand;
            end
            riscv_pkg::ALU_AND: begin
                result = left_operand & right_operand;
            end
            riscv_pkg::ALU_OR: begin
                result = left_operand | right_operand;
            end
            riscv_pkg::ALU_XOR: begin
                result = left_operand ^ right_operand;
            end
            riscv_pkg::ALU_SLL: begin
                result = left_operand << shamt;
            end
            riscv_pkg::ALU_SRL: begin
                result = left_operand >> shamt;
            end
            riscv_pkg::ALU_SRA: begin
                result = $unsigned($signed(left_operand) >>> shamt);
            end
            riscv_pkg::ALU_SLT: begin
                result = {31'd0, $signed(left_operand) < $signed(right_operand)};
            end
            riscv_pkg::ALU_SLTU: begin
                result = {31'd0, left_operand < right_operand};
            end
            default: begin
                result = left_operand + right_operand;
            end
        endcase
    end

    // Branch equality comes from ALU_SUB giving zero
    assign zero_flag = (result == 32'd0);

endmodule

//--- source/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit (
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              ex_mem_rd,
    input  logic [4:0]              wb_rd,
    input  logic                    ex_mem_reg_write,
    input  logic                    wb_reg_write,
    output riscv_pkg::forward_sel_t forward_a,
    output riscv_pkg::forward_sel_t forward_b
);

    // The younger result in EX/MEM takes priority over MEM/WB
    // x0 reads as zero and never takes a forwarded value
    function automatic riscv_pkg::forward_sel_t pick_source(
        input logic [4:0] rs,
        input logic [4:0] mem_rd,
        input logic       mem_we,
        input logic [4:0] last_rd,
        input logic       last_we
    );
        if (mem_we && mem_rd != 5'd0 && mem_rd == rs) begin
            pick_source = riscv_pkg::FWD_EX_MEM;
        end else if (last_we && last_rd != 5'd0 && last_rd == rs) begin
            pick_source = riscv_pkg::FWD_MEM_WB;
        end else begin
            pick_source = riscv_pkg::FWD_NONE;
        end
    endfunction

    always_comb begin
        forward_a = pick_source(rs1, ex_mem_rd, ex_mem_reg_write, wb_rd, wb_reg_write);
        forward_b = pick_source(rs2, ex_mem_rd, ex_mem_reg_write, wb_rd, wb_reg_write);
    end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             data1,
    input  logic [31:0]             data2,
    input  logic [31:0]             immediate_data,
    input  logic [31:0]             pc_in,
    input  logic [31:0]             ex_mem_forward_data,
    input  logic [31:0]             wb_forward_data,
    input  riscv_pkg::alu_op_t      alu_op,
    input  riscv_pkg::encoding_t    encoding,
    input  logic                    alu_src,
    input  logic                    is_branch,
    input  riscv_pkg::forward_sel_t forward_a,
    input  riscv_pkg::forward_sel_t forward_b,
    output logic [31:0]             alu_data,
    output logic [31:0]             store_data,
    output logic                    pc_src
);

    logic [31:0] left_operand;
    logic [31:0] right_operand;
    logic [31:0] alu_result;
    logic        zero_flag;
    logic        is_jalr;

    function automatic logic [31:0] pick_operand(
        input riscv_pkg::forward_sel_t sel,
        input logic [31:0]             reg_value,
        input logic [31:0]             mem_value,
        input logic [31:0]             wb_value
    );
        case (sel)
            riscv_pkg::FWD_EX_MEM: pick_operand = mem_value;
            riscv_pkg::FWD_MEM_WB: pick_operand = wb_value;
            default:               pick_operand = reg_value;
        endcase
    endfunction

    // Operand b is forwarded before the immediate mux
    always_comb begin
        left_operand = pick_operand(forward_a, data1, ex_mem_forward_data, wb_forward_data);
        store_data   = pick_operand(forward_b, data2, ex_mem_forward_data, wb_forward_data);
        if (alu_src) begin
            right_operand = immediate_data;
        end else begin
            right_operand = store_data;
        end
    end

    alu i_alu (
        .control       (alu_op),
        .left_operand  (left_operand),
        .right_operand (right_operand),
        .result        (alu_result),
        .zero_flag     (zero_flag)
    );

    // JALR is an I-type carrying the branch flag
    assign is_jalr = (encoding == riscv_pkg::I_TYPE) && is_branch;

    // Jumps write back the return address
    assign alu_data = (encoding == riscv_pkg::J_TYPE || is_jalr) ? pc_in + 32'd4 : alu_result;

    assign pc_src = is_jalr || (is_branch && zero_flag);

    // The forwarding unit never drives the spare select code
    assert property (@(posedge clk) disable iff (!rst_n)
        forward_a != 2'b11 && forward_b != 2'b11)
    else $error("execute_stage: unused forward select code");

endmodule

//--- source/ex_wb_pipeline.sv
`timescale 1ns/1ns

module ex_wb_pipeline (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic [31:0] alu_data,
    input  logic [31:0] store_data,
    input  logic [31:0] mem_read_data,
    input  logic [4:0]  rd,
    input  logic        reg_write,
    input  logic        mem_read,
    input  logic        mem_write,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic        mem_read_en,
    output logic        mem_write_en,
    output logic [4:0]  ex_mem_rd,
    output logic        ex_mem_reg_write,
    output logic [31:0] wb_data,
    output logic [4:0]  wb_rd,
    output logic        wb_reg_write
);

    // EX/MEM stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_addr         <= 32'd0;
            mem_wdata        <= 32'd0;
            mem_read_en      <= 1'b0;
            mem_write_en     <= 1'b0;
            ex_mem_rd        <= 5'd0;
            ex_mem_reg_write <= 1'b0;
        end else if (!stall) begin
            mem_addr         <= alu_data;
            mem_wdata        <= store_data;
            mem_read_en      <= mem_read;
            mem_write_en     <= mem_write;
            ex_mem_rd        <= rd;
            ex_mem_reg_write <= reg_write;
        end
    end

    // Loads take the memory data into MEM/WB instead of the address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_data      <= 32'd0;
            wb_rd        <= 5'd0;
            wb_reg_write <= 1'b0;
        end else if (!stall) begin
            wb_data      <= mem_read_en ? mem_read_data : mem_addr;
            wb_rd        <= ex_mem_rd;
            wb_reg_write <= ex_mem_reg_write;
        end
    end

    // Decode never issues an access that both loads and stores
    assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read_en && mem_write_en))
    else $error("ex_wb_pipeline: read and write enables both set");

endmodule

//--- source/execute_subsystem.sv
`timescale 1ns/1ns

module execute_subsystem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic [31:0]          data1,
    input  logic [31:0]          data2,
    input  logic [31:0]          immediate_data,
    input  logic [31:0]          pc_in,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  logic [4:0]           rd,
    input  riscv_pkg::alu_op_t   alu_op,
    input  riscv_pkg::encoding_t encoding,
    input  logic                 alu_src,
    input  logic                 is_branch,
    input  logic                 reg_write,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic [31:0]          mem_read_data,
    output logic                 pc_src,
    output logic [31:0]          mem_addr,
    output logic [31:0]          mem_wdata,
    output logic                 mem_read_en,
    output logic                 mem_write_en,
    output logic [4:0]           ex_mem_rd,
    output logic                 ex_mem_reg_write,
    output logic [31:0]          wb_data,
    output logic [4:0]           wb_rd,
    output logic                 wb_reg_write
);

    logic [31:0]             alu_data;
    logic [31:0]             store_data;
    riscv_pkg::forward_sel_t forward_a;
    riscv_pkg::forward_sel_t forward_b;

    forwarding_unit i_forwarding_unit (
        .rs1              (rs1),
        .rs2              (rs2),
        .ex_mem_rd        (ex_mem_rd),
        .wb_rd            (wb_rd),
        .ex_mem_reg_write (ex_mem_reg_write),
        .wb_reg_write     (wb_reg_write),
        .forward_a        (forward_a),
        .forward_b        (forward_b)
    );

    // EX/MEM result is forwarded straight from the registered address
    execute_stage i_execute_stage (
        .clk                 (clk),
        .rst_n               (rst_n),
        .data1               (data1),
        .data2               (data2),
        .immediate_data      (immediate_data),
        .pc_in               (pc_in),
        .ex_mem_forward_data (mem_addr),
        .wb_forward_data     (wb_data),
        .alu_op              (alu_op),
        .encoding            (encoding),
        .alu_src             (alu_src),
        .is_branch           (is_branch),
        .forward_a           (forward_a),
        .forward_b           (forward_b),
        .alu_data            (alu_data),
        .store_data          (store_data),
        .pc_src              (pc_src)
    );

    ex_wb_pipeline i_ex_wb_pipeline (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall            (stall),
        .alu_data         (alu_data),
        .store_data       (store_data),
        .mem_read_data    (mem_read_data),
        .rd               (rd),
        .reg_write        (reg_write),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata),
        .mem_read_en      (mem_read_en),
        .mem_write_en     (mem_write_en),
        .ex_mem_rd        (ex_mem_rd),
        .ex_mem_reg_write (ex_mem_reg_write),
        .wb_data          (wb_data),
        .wb_rd            (wb_rd),
        .wb_reg_write     (wb_reg_write)
    );

endmodule

//--- test/tb_execute_subsystem.sv
`timescale 1ns/1ns

module tb_execute_subsystem;

    logic clk;
    logic rst_n;
    logic stall;
    logic [31:0] data1;
    logic [31:0] data2;
    logic [31:0] immediate_data;
    logic [31:0] pc_in;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    riscv_pkg::alu_op_t alu_op;
    riscv_pkg::encoding_t encoding;
    logic alu_src;
    logic is_branch;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic [31:0] mem_read_data;
    logic pc_src;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic mem_read_en;
    logic mem_write_en;
    logic [4:0] ex_mem_rd;
    logic ex_mem_reg_write;
    logic [31:0] wb_data;
    logic [4:0] wb_rd;
    logic wb_reg_write;

    // Stimulus table with one instruction per cycle
    riscv_pkg::alu_op_t   t_op [0:31];
    riscv_pkg::encoding_t t_enc [0:31];
    logic [6:0]  t_ctrl [0:31];
    logic [4:0]  t_rs1 [0:31];
    logic [4:0]  t_rs2 [0:31];
    logic [4:0]  t_rd [0:31];
    logic [31:0] t_d1 [0:31];
    logic [31:0] t_d2 [0:31];
    logic [31:0] t_imm [0:31];
    logic [31:0] t_pc [0:31];
    logic [31:0] t_rdata [0:31];
    logic        t_pc_src [0:31];
    int n_entries = 0;
    int errors = 0;
    int test_errors;
    int failed_tests = 0;
    logic [31:0] rng_state = 32'h26c1;

    // Model of the EX/MEM and MEM/WB registers
    logic [31:0] m_addr, m_wdata, m_wb_data;
    logic [4:0]  m_ex_rd, m_wb_rd;
    logic        m_ex_we, m_rd_en, m_wr_en, m_wb_we;

    execute_subsystem i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] expected_alu(input riscv_pkg::alu_op_t op,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (op)
            riscv_pkg::ALU_SUB:  return a - b;
            riscv_pkg::ALU_AND:  return a & b;
            riscv_pkg::ALU_OR:   return a | b;
            riscv_pkg::ALU_XOR:  return a ^ b;
            riscv_pkg::ALU_SLL:  return a << b[4:0];
            riscv_pkg::ALU_SRL:  return a >> b[4:0];
            riscv_pkg::ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            riscv_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            riscv_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:             return a + b;
        endcase
    endfunction

    // EX/MEM wins over MEM/WB and x0 is never forwarded
    function automatic logic [31:0] forwarded(input logic [4:0] rs, input logic [31:0] value);
        if (m_ex_we && m_ex_rd != 5'd0 && m_ex_rd == rs) return m_addr;
        if (m_wb_we && m_wb_rd != 5'd0 && m_wb_rd == rs) return m_wb_data;
        return value;
    endfunction

    // ctrl bits are {stall, alu_src, is_branch, reg_write, mem_read, mem_write, pc_src}
    task automatic add_entry(input riscv_pkg::alu_op_t op, input riscv_pkg::encoding_t enc,
                             input logic [6:0] ctrl, input logic [4:0] s1, input logic [4:0] s2,
                             input logic [4:0] d, input logic [31:0] v1, input logic [31:0] v2,
                             input logic [31:0] imm, input logic [31:0] rdata);
        t_op[n_entries]     = op;
        t_enc[n_entries]    = enc;
        t_ctrl[n_entries]   = ctrl;
        t_rs1[n_entries]    = s1;
        t_rs2[n_entries]    = s2;
        t_rd[n_entries]     = d;
        t_d1[n_entries]     = v1;
        t_d2[n_entries]     = v2;
        t_imm[n_entries]    = imm;
        t_pc[n_entries]     = 32'h1000 + 32'(n_entries * 4);
        t_rdata[n_entries]  = rdata;
        t_pc_src[n_entries] = ctrl[0];
        n_entries++;
    endtask

    // Upstream holds its outputs while stalled
    task automatic hold_previous();
        add_entry(t_op[n_entries-1], t_enc[n_entries-1], t_ctrl[n_entries-1] | 7'b1000000,
                  t_rs1[n_entries-1], t_rs2[n_entries-1], t_rd[n_entries-1],
                  t_d1[n_entries-1], t_d2[n_entries-1], t_imm[n_entries-1], t_rdata[n_entries-1]);
        t_pc[n_entries-1] = t_pc[n_entries-2];
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    initial begin
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::R_TYPE, 7'b0001000, 10, 11, 1,
                  next_random(), next_random(), 0, 0);
        add_entry(riscv_pkg::ALU_SUB, riscv_pkg::I_TYPE, 7'b0101000, 12, 0, 2,
                  next_random(), 0, 100, 0);
        add_entry(riscv_pkg::ALU_XOR, riscv_pkg::R_TYPE, 7'b0001000, 1, 2, 3,
                  next_random(), next_random(), 0, 0);
        add_entry(riscv_pkg::ALU_AND, riscv_pkg::R_TYPE, 7'b0001000, 3, 3, 3,
                  next_random(), next_random(), 0, 0);
        add_entry(riscv_pkg::ALU_OR, riscv_pkg::R_TYPE, 7'b0001000, 3, 5, 0,
                  next_random(), next_random(), 0, 0);
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::R_TYPE, 7'b0001000, 0, 0, 4, 0, 0, 0, 0);
        add_entry(riscv_pkg::ALU_SLL, riscv_pkg::I_TYPE, 7'b0101000, 4, 0, 5,
                  next_random(), 0, 5, 0);
        add_entry(riscv_pkg::ALU_SRL, riscv_pkg::R_TYPE, 7'b0001000, 13, 14, 6,
                  next_random(), next_random(), 0, 0);
        add_entry(riscv_pkg::ALU_SRA, riscv_pkg::I_TYPE, 7'b0101000, 15, 0, 8,
                  32'h8000_0f00, 0, 7, 0);
        add_entry(riscv_pkg::ALU_SLT, riscv_pkg::R_TYPE, 7'b0001000, 16, 17, 9,
                  32'hffff_fff0, 3, 0, 0);
        add_entry(riscv_pkg::ALU_SLTU, riscv_pkg::R_TYPE, 7'b0001000, 16, 17, 10,
                  32'hffff_fff0, 3, 0, 0);
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::S_TYPE, 7'b0100010, 10, 9, 0,
                  next_random(), next_random(), 16, 0);
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::I_TYPE, 7'b0101100, 18, 0, 7,
                  32'h200, 0, 8, 0);
        add_entry(riscv_pkg::ALU_XOR, riscv_pkg::R_TYPE, 7'b0001000, 19, 22, 11,
                  next_random(), next_random(), 0, 32'hcafe_0123);
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::R_TYPE, 7'b0001000, 7, 11, 12,
                  next_random(), next_random(), 0, 0);
        add_entry(riscv_pkg::ALU_SUB, riscv_pkg::B_TYPE, 7'b0010001, 20, 21, 0,
                  32'h55, 32'h55, 0, 0);
        add_entry(riscv_pkg::ALU_SUB, riscv_pkg::B_TYPE, 7'b0010000, 20, 21, 0,
                  32'h55, 32'h56, 0, 0);
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::I_TYPE, 7'b0111001, 23, 0, 13,
                  32'h4000, 0, 12, 0);
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::J_TYPE, 7'b0101000, 0, 0, 14, 0, 0, 32'h40, 0);
        add_entry(riscv_pkg::ALU_OR, riscv_pkg::R_TYPE, 7'b0001000, 14, 13, 15,
                  next_random(), next_random(), 0, 0);
        hold_previous();
        hold_previous();
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::R_TYPE, 7'b0001000, 15, 14, 16,
                  next_random(), next_random(), 0, 0);
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::R_TYPE, 7'b0000000, 0, 0, 0, 0, 0, 0, 0);
        add_entry(riscv_pkg::ALU_ADD, riscv_pkg::R_TYPE, 7'b0000000, 0, 0, 0, 0, 0, 0, 0);
    end

    initial begin
        #1;
        #((2 * n_entries + 4) * 100);
        $display("Timeout: the run did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] link;
        logic        jalr;
        logic        exp_pc_src;
        {stall, data1, data2, immediate_data, pc_in, rs1, rs2, rd} = '0;
        {alu_src, is_branch, reg_write, mem_read, mem_write, mem_read_data} = '0;
        alu_op = riscv_pkg::ALU_ADD;
        encoding = riscv_pkg::R_TYPE;
        rst_n = 1'b0;
        {m_addr, m_wdata, m_wb_data, m_ex_rd, m_wb_rd} = '0;
        {m_ex_we, m_rd_en, m_wr_en, m_wb_we} = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        if ({mem_read_en, mem_write_en, ex_mem_reg_write, wb_reg_write} !== 4'b0000) begin
            $display("Control outputs are not cleared by reset");
            errors++;
        end
        for (int i = 0; i < n_entries; i++) begin
            @(posedge clk);
            #1;
            test_errors = 0;
            {stall, alu_src, is_branch, reg_write, mem_read, mem_write} = t_ctrl[i][6:1];
            alu_op = t_op[i];
            encoding = t_enc[i];
            {rs1, rs2, rd} = {t_rs1[i], t_rs2[i], t_rd[i]};
            {data1, data2, immediate_data, pc_in} = {t_d1[i], t_d2[i], t_imm[i], t_pc[i]};
            mem_read_data = t_rdata[i];
            a = forwarded(t_rs1[i], t_d1[i]);
            b = forwarded(t_rs2[i], t_d2[i]);
            res = expected_alu(t_op[i], a, t_ctrl[i][5] ? t_imm[i] : b);
            jalr = (t_enc[i] == riscv_pkg::I_TYPE) && t_ctrl[i][4];
            link = (t_enc[i] == riscv_pkg::J_TYPE || jalr) ? t_pc[i] + 32'd4 : res;
            exp_pc_src = jalr || (t_ctrl[i][4] && res == 32'd0);
            #49;
            compare("pc_src", pc_src, t_pc_src[i]);
            compare("model pc_src", exp_pc_src, t_pc_src[i]);
            compare("mem_addr", mem_addr, m_addr);
            compare("mem_wdata", mem_wdata, m_wdata);
            compare("mem_read_en", mem_read_en, m_rd_en);
            compare("mem_write_en", mem_write_en, m_wr_en);
            compare("ex_mem_rd", ex_mem_rd, m_ex_rd);
            compare("ex_mem_reg_write", ex_mem_reg_write, m_ex_we);
            compare("wb_data", wb_data, m_wb_data);
            compare("wb_rd", wb_rd, m_wb_rd);
            compare("wb_reg_write", wb_reg_write, m_wb_we);
            if (!t_ctrl[i][6]) begin
                m_wb_data = m_rd_en ? t_rdata[i] : m_addr;
                {m_wb_rd, m_wb_we} = {m_ex_rd, m_ex_we};
                {m_addr, m_wdata, m_ex_rd} = {link, b, t_rd[i]};
                {m_ex_we, m_rd_en, m_wr_en} = t_ctrl[i][3:1];
            end
            $display("test %0d: %s, %0d errors", i, (test_errors == 0) ? "ok" : "failed",
                     test_errors);
            errors += test_errors;
            if (test_errors != 0) failed_tests++;
        end
        $display("tests %0d, failed %0d, errors %0d", n_entries, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- execute_subsystem.f
source/riscv_pkg.sv
source/alu.sv
source/forwarding_unit.sv
source/execute_stage.sv
source/ex_wb_pipeline.sv
source/execute_subsystem.sv
test/tb_execute_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wall -Wno-fatal \
    -f execute_subsystem.f \
    --top-module tb_execute_subsystem \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
